// File: Bender.yml
package:
  name: decode_front_end

sources:
  - hw/riscv_pkg.sv
  - hw/pipe_pkg.sv
  - hw/main_decoder.sv
  - hw/imm_gen.sv
  - hw/fetch_unit.sv
  - hw/instr_fifo.sv
  - hw/decode_stage.sv
  - hw/decode_top.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/tb_decode_top.sv

// File: hw/decode_stage.sv
`timescale 1ns/100ps

module decode_stage #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fifo_valid,
    input  riscv_pkg::instr_t      fifo_instr,
    input  pipe_pkg::pc_t          fifo_pc,
    output logic                   pop,
    input  logic                   out_credit,
    output logic                   out_valid,
    output pipe_pkg::pc_t          out_pc,
    output riscv_pkg::imm_t        out_imm,
    output logic                   out_jump,
    output logic                   out_branch,
    output riscv_pkg::result_src_t out_result_src,
    output logic                   out_mem_write,
    output logic                   out_alu_src,
    output riscv_pkg::imm_src_t    out_imm_src,
    output logic                   out_reg_write,
    output riscv_pkg::alu_op_t     out_alu_op,
    output logic                   out_jalr,
    output logic                   out_op1_pc,
    output logic                   out_rs1_used,
    output logic                   out_rs2_used,
    output logic                   out_mul_en,
    output logic                   out_div_en,
    output logic                   out_illegal
);

    pipe_pkg::credit_t      credits; // Slots free in the execute stage
    logic                   jump, branch, mem_write, alu_src, reg_write, jalr;
    logic                   op1_pc, rs1_used, rs2_used, mul_en, div_en, illegal;
    riscv_pkg::result_src_t result_src;
    riscv_pkg::imm_src_t    imm_src;
    riscv_pkg::alu_op_t     alu_op;
    riscv_pkg::imm_t        imm;

    main_decoder main_decoder_i (
        .opcode(fifo_instr[6:0]), .jump(jump), .branch(branch), .result_src(result_src),
        .mem_write(mem_write), .alu_src(alu_src), .imm_src(imm_src),
        .reg_write(reg_write), .alu_op(alu_op), .jalr(jalr), .op1_pc(op1_pc),
        .rs1_used(rs1_used), .rs2_used(rs2_used), .mul_en(mul_en), .div_en(div_en),
        .illegal(illegal)
    );

    imm_gen imm_gen_i (.instr(fifo_instr), .imm_src(imm_src), .imm(imm));

    assign pop = fifo_valid && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits   <= pipe_pkg::credit_t'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop; // Single cycle per instruction
            credits   <= credits - pipe_pkg::credit_t'(pop)
                         + pipe_pkg::credit_t'(out_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_pc         <= fifo_pc;
            out_imm        <= imm;
            out_jump       <= jump;
            out_branch     <= branch;
            out_result_src <= result_src;
            out_mem_write  <= mem_write;
            out_alu_src    <= alu_src;
            out_imm_src    <= imm_src;
            out_reg_write  <= reg_write;
            out_alu_op     <= alu_op;
            out_jalr       <= jalr;
            out_op1_pc     <= op1_pc;
            out_rs1_used   <= rs1_used;
            out_rs2_used   <= rs2_used;
            out_mul_en     <= mul_en;
            out_div_en     <= div_en;
            out_illegal    <= illegal;
        end
    end

    // Consumer must never return more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= pipe_pkg::credit_t'(OUT_CREDITS));

endmodule

// File: hw/decode_top.sv
`timescale 1ns/100ps

module decode_top #(
    parameter int            FIFO_DEPTH  = 4,
    parameter int            OUT_CREDITS = 2,
    parameter pipe_pkg::pc_t RESET_PC    = '0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  riscv_pkg::instr_t      in_instr,
    output logic                   in_credit,
    input  logic                   out_credit,
    output logic                   out_valid,
    output pipe_pkg::pc_t          out_pc,
    output riscv_pkg::imm_t        out_imm,
    output logic                   out_jump,
    output logic                   out_branch,
    output riscv_pkg::result_src_t out_result_src,
    output logic                   out_mem_write,
    output logic                   out_alu_src,
    output riscv_pkg::imm_src_t    out_imm_src,
    output logic                   out_reg_write,
    output riscv_pkg::alu_op_t     out_alu_op,
    output logic                   out_jalr,
    output logic                   out_op1_pc,
    output logic                   out_rs1_used,
    output logic                   out_rs2_used,
    output logic                   out_mul_en,
    output logic                   out_div_en,
    output logic                   out_illegal
);

    logic              push, pop, fifo_valid, fifo_credit;
    riscv_pkg::instr_t push_instr, fifo_instr;
    pipe_pkg::pc_t     push_pc, fifo_pc;

    fetch_unit #(.FIFO_DEPTH(FIFO_DEPTH), .RESET_PC(RESET_PC)) fetch_unit_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
        .in_credit(in_credit), .push(push), .push_instr(push_instr),
        .push_pc(push_pc), .fifo_credit(fifo_credit)
    );

    instr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) instr_fifo_i (
        .clk(clk), .rst(rst), .push(push), .push_instr(push_instr),
        .push_pc(push_pc), .fifo_valid(fifo_valid), .fifo_instr(fifo_instr),
        .fifo_pc(fifo_pc), .pop(pop), .fifo_credit(fifo_credit)
    );

    decode_stage #(.OUT_CREDITS(OUT_CREDITS)) decode_stage_i (
        .clk(clk), .rst(rst), .fifo_valid(fifo_valid), .fifo_instr(fifo_instr),
        .fifo_pc(fifo_pc), .pop(pop), .out_credit(out_credit), .out_valid(out_valid),
        .out_pc(out_pc), .out_imm(out_imm), .out_jump(out_jump),
        .out_branch(out_branch), .out_result_src(out_result_src),
        .out_mem_write(out_mem_write), .out_alu_src(out_alu_src),
        .out_imm_src(out_imm_src), .out_reg_write(out_reg_write),
        .out_alu_op(out_alu_op), .out_jalr(out_jalr), .out_op1_pc(out_op1_pc),
        .out_rs1_used(out_rs1_used), .out_rs2_used(out_rs2_used),
        .out_mul_en(out_mul_en), .out_div_en(out_div_en), .out_illegal(out_illegal)
    );

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
    parameter int            FIFO_DEPTH = 4,
    parameter pipe_pkg::pc_t RESET_PC   = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  riscv_pkg::instr_t in_instr,
    output logic              in_credit,
    output logic              push,
    output riscv_pkg::instr_t push_instr,
    output pipe_pkg::pc_t     push_pc,
    input  logic              fifo_credit
);

    logic              slot_valid;
    riscv_pkg::instr_t slot_instr;
    pipe_pkg::pc_t     slot_pc;
    pipe_pkg::pc_t     pc;
    pipe_pkg::credit_t credits; // Free FIFO entries as seen from here

    assign push       = slot_valid && (credits != '0);
    assign push_instr = slot_instr;
    assign push_pc    = slot_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= 1'b0;
            pc         <= RESET_PC;
            credits    <= pipe_pkg::credit_t'(FIFO_DEPTH);
            in_credit  <= 1'b0;
        end else begin
            in_credit <= push; // Slot freed, source may send again
            credits   <= credits - pipe_pkg::credit_t'(push)
                         + pipe_pkg::credit_t'(fifo_credit);
            if (push)
                slot_valid <= 1'b0;
            if (in_valid) begin
                slot_valid <= 1'b1;
                pc         <= pc + 32'd4; // No redirect in this front end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            slot_instr <= in_instr; // Tag with the current PC
            slot_pc    <= pc;
        end
    end

    a_push_credit: assert property (@(posedge clk) disable iff (rst)
        push |-> credits inside {[1:FIFO_DEPTH]});

    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !slot_valid);

endmodule

// File: hw/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
    input  riscv_pkg::instr_t   instr,
    input  riscv_pkg::imm_src_t imm_src,
    output riscv_pkg::imm_t     imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            riscv_pkg::IMM_I: imm = {{20{sign}}, instr[31:20]};
            riscv_pkg::IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            riscv_pkg::IMM_B: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            riscv_pkg::IMM_J: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            riscv_pkg::IMM_U: imm = {instr[31:12], 12'b0}; // Upper bits only
            default:          imm = '0;
        endcase
    end

endmodule

// File: hw/instr_fifo.sv
`timescale 1ns/100ps

module instr_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  riscv_pkg::instr_t push_instr,
    input  pipe_pkg::pc_t     push_pc,
    output logic              fifo_valid,
    output riscv_pkg::instr_t fifo_instr,
    output pipe_pkg::pc_t     fifo_pc,
    input  logic              pop,
    output logic              fifo_credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    riscv_pkg::instr_t mem_instr [FIFO_DEPTH];
    pipe_pkg::pc_t     mem_pc    [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1; // Wraps for any depth
    endfunction

    assign fifo_valid = (count != '0);
    assign fifo_instr = mem_instr[rd_ptr];
    assign fifo_pc    = mem_pc[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            fifo_credit <= 1'b0;
        end else begin
            fifo_credit <= pop; // One credit back per entry freed
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_instr[wr_ptr] <= push_instr;
            mem_pc[wr_ptr]    <= push_pc;
        end
    end

    // Fetch credits must keep the writer from overfilling
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count < CNT_W'(FIFO_DEPTH)) || pop);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> fifo_valid);

endmodule

// File: hw/main_decoder.sv
`timescale 1ns/100ps

module main_decoder (
    input  riscv_pkg::opcode_t     opcode,

    output logic                   jump,
    output logic                   branch,
    output riscv_pkg::result_src_t result_src,
    output logic                   mem_write,
    output logic                   alu_src,
    output riscv_pkg::imm_src_t    imm_src,
    output logic                   reg_write,
    output riscv_pkg::alu_op_t     alu_op,
    output logic                   jalr,
    output logic                   op1_pc,
    output logic                   rs1_used,
    output logic                   rs2_used,
    output logic                   mul_en,
    output logic                   div_en,
    output logic                   illegal
);

    always_comb begin
        jump       = 1'b0; // Everything off unless the opcode says otherwise
        branch     = 1'b0;
        result_src = riscv_pkg::RES_ALU;
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        imm_src    = riscv_pkg::IMM_I;
        reg_write  = 1'b0;
        alu_op     = riscv_pkg::ALU_ADD;
        jalr       = 1'b0;
        op1_pc     = 1'b0;
        rs1_used   = 1'b0;
        rs2_used   = 1'b0;
        mul_en     = 1'b0;
        div_en     = 1'b0;
        illegal    = 1'b0;

        case (opcode)
            riscv_pkg::OP_R: begin
                reg_write = 1'b1;
                alu_op    = riscv_pkg::ALU_FUNCT;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
            end
            riscv_pkg::OP_LOAD: begin
                result_src = riscv_pkg::RES_MEM;
                alu_src    = 1'b1;
                reg_write  = 1'b1; // Address is rs1 + imm
                rs1_used   = 1'b1;
            end
            riscv_pkg::OP_IMM: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_op    = riscv_pkg::ALU_FUNCT;
                rs1_used  = 1'b1;
            end
            riscv_pkg::OP_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = riscv_pkg::IMM_S;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
            end
            riscv_pkg::OP_BRANCH: begin
                branch   = 1'b1;
                imm_src  = riscv_pkg::IMM_B;
                alu_op   = riscv_pkg::ALU_SUB; // Compare by subtraction
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            riscv_pkg::OP_JALR: begin
                jump      = 1'b1;
                alu_src   = 1'b1;
                reg_write = 1'b1;
                jalr      = 1'b1; // Target is rs1 + imm
                rs1_used  = 1'b1;
            end
            riscv_pkg::OP_JAL: begin
                jump       = 1'b1;
                result_src = riscv_pkg::RES_PC4; // Link address
                alu_src    = 1'b1;
                imm_src    = riscv_pkg::IMM_J;
                reg_write  = 1'b1;
            end
            riscv_pkg::OP_LUI: begin
                alu_src   = 1'b1;
                imm_src   = riscv_pkg::IMM_U;
                reg_write = 1'b1;
                alu_op    = riscv_pkg::ALU_LUI;
            end
            riscv_pkg::OP_AUIPC: begin
                alu_src   = 1'b1;
                imm_src   = riscv_pkg::IMM_U;
                reg_write = 1'b1;
                op1_pc    = 1'b1; // PC replaces rs1
            end
            riscv_pkg::OP_MUL: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_op    = riscv_pkg::ALU_MUL;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                mul_en    = 1'b1;
            end
            riscv_pkg::OP_DIV: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_op    = riscv_pkg::ALU_DIV;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                div_en    = 1'b1;
            end
            default: illegal = 1'b1; // Controls stay at zero
        endcase
    end

endmodule

// File: hw/pipe_pkg.sv
package pipe_pkg;

    typedef logic [31:0] pc_t;

    // Enough for depths up to 15
    typedef logic [3:0] credit_t;

endpackage

// File: hw/riscv_pkg.sv
package riscv_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [31:0] imm_t;
    typedef logic [2:0]  imm_src_t;
    typedef logic [1:0]  result_src_t;
    typedef logic [2:0]  alu_op_t;

    // Immediate formats
    localparam imm_src_t IMM_I = 3'd0;
    localparam imm_src_t IMM_S = 3'd1;
    localparam imm_src_t IMM_B = 3'd2;
    localparam imm_src_t IMM_J = 3'd3;
    localparam imm_src_t IMM_U = 3'd4;

    // Writeback source
    localparam result_src_t RES_ALU = 2'd0;
    localparam result_src_t RES_MEM = 2'd1;
    localparam result_src_t RES_PC4 = 2'd2;

    // ALU operation classes
    localparam alu_op_t ALU_ADD   = 3'd0;
    localparam alu_op_t ALU_SUB   = 3'd1;
    localparam alu_op_t ALU_FUNCT = 3'd2; // Resolved later from funct3/funct7
    localparam alu_op_t ALU_LUI   = 3'd3;
    localparam alu_op_t ALU_MUL   = 3'd4;
    localparam alu_op_t ALU_DIV   = 3'd5;

    // Opcodes, RV32I plus the custom multiply and divide
    localparam opcode_t OP_R      = 7'd51;
    localparam opcode_t OP_LOAD   = 7'd3;
    localparam opcode_t OP_IMM    = 7'd19;
    localparam opcode_t OP_STORE  = 7'd35;
    localparam opcode_t OP_BRANCH = 7'd99;
    localparam opcode_t OP_JALR   = 7'd103;
    localparam opcode_t OP_JAL    = 7'd111;
    localparam opcode_t OP_LUI    = 7'd55;
    localparam opcode_t OP_AUIPC  = 7'd23;
    localparam opcode_t OP_MUL    = 7'd67; // Custom
    localparam opcode_t OP_DIV    = 7'd68; // Custom

endpackage

// File: src.f
hw/riscv_pkg.sv
hw/pipe_pkg.sv
hw/main_decoder.sv
hw/imm_gen.sv
hw/fetch_unit.sv
hw/instr_fifo.sv
hw/decode_stage.sv
hw/decode_top.sv
tests/clk_gen.sv
tests/tb_decode_top.sv

// File: tests/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0; // Released on the edge after the last reset cycle
    end

endmodule

// File: tests/tb_decode_top.sv
`timescale 1ns/100ps

module tb_decode_top;

    localparam int            FIFO_DEPTH  = 4;
    localparam int            OUT_CREDITS = 2;
    localparam pipe_pkg::pc_t RESET_PC    = 32'h0000_0100;
    localparam int            TIMEOUT     = 2000; // Cycles allowed per wait
    localparam int            NUM_INSTR   = 64;

    typedef struct packed {
        pipe_pkg::pc_t          pc;
        riscv_pkg::imm_t        imm;
        logic                   jump;
        logic                   branch;
        riscv_pkg::result_src_t result_src;
        logic                   mem_write;
        logic                   alu_src;
        riscv_pkg::imm_src_t    imm_src;
        logic                   reg_write;
        riscv_pkg::alu_op_t     alu_op;
        logic                   jalr;
        logic                   op1_pc;
        logic                   rs1_used;
        logic                   rs2_used;
        logic                   mul_en;
        logic                   div_en;
        logic                   illegal;
    } expect_t;

    logic                   clk, rst, in_valid, in_credit, out_credit, out_valid;
    riscv_pkg::instr_t      in_instr;
    pipe_pkg::pc_t          out_pc;
    riscv_pkg::imm_t        out_imm;
    riscv_pkg::result_src_t out_result_src;
    riscv_pkg::imm_src_t    out_imm_src;
    riscv_pkg::alu_op_t     out_alu_op;
    logic                   out_jump, out_branch, out_mem_write, out_alu_src, out_reg_write;
    logic                   out_jalr, out_op1_pc, out_rs1_used, out_rs2_used, out_mul_en;
    logic                   out_div_en, out_illegal;

    riscv_pkg::opcode_t     legal_ops [11];
    riscv_pkg::instr_t      stim [$];
    int                     src_gap [$];
    int                     ret_gap [$];
    expect_t                exp_q [$];
    int                     seed = 77868;
    int                     sent, credit_pulses, received, returned, pulses, owed;

    clk_gen #(.PERIOD(8), .RESET_CYCLES(5)) clk_gen_i (.clk(clk), .rst(rst));

    decode_top #(
        .FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS), .RESET_PC(RESET_PC)
    ) decode_top_i (.*);

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        if (got !== expected) begin
            $display("error %s expected %h got %h", name, expected, got);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic is_legal(input riscv_pkg::opcode_t op);
        foreach (legal_ops[k])
            if (legal_ops[k] == op)
                return 1'b1;
        return 1'b0;
    endfunction

    // Control word from the opcode tables, immediate per RV32I bit placement
    function automatic expect_t expected_decode(input riscv_pkg::instr_t instr,
                                                input pipe_pkg::pc_t pc);
        logic               r, ld, im, st, br, jr, jl, lui, aui, mul, dv;
        logic signed [31:0] t;
        expect_t            e;
        r   = instr[6:0] == riscv_pkg::OP_R;
        ld  = instr[6:0] == riscv_pkg::OP_LOAD;
        im  = instr[6:0] == riscv_pkg::OP_IMM;
        st  = instr[6:0] == riscv_pkg::OP_STORE;
        br  = instr[6:0] == riscv_pkg::OP_BRANCH;
        jr  = instr[6:0] == riscv_pkg::OP_JALR;
        jl  = instr[6:0] == riscv_pkg::OP_JAL;
        lui = instr[6:0] == riscv_pkg::OP_LUI;
        aui = instr[6:0] == riscv_pkg::OP_AUIPC;
        mul = instr[6:0] == riscv_pkg::OP_MUL;
        dv  = instr[6:0] == riscv_pkg::OP_DIV;
        e = '0;
        e.pc         = pc;
        e.illegal    = !(r | ld | im | st | br | jr | jl | lui | aui | mul | dv);
        e.jump       = jl | jr;
        e.branch     = br;
        e.result_src = ld ? riscv_pkg::RES_MEM : (jl ? riscv_pkg::RES_PC4 : riscv_pkg::RES_ALU);
        e.mem_write  = st;
        e.alu_src    = ld | im | st | jr | jl | lui | aui | mul | dv;
        e.imm_src    = st ? riscv_pkg::IMM_S : br ? riscv_pkg::IMM_B : jl ? riscv_pkg::IMM_J :
                       (lui | aui) ? riscv_pkg::IMM_U : riscv_pkg::IMM_I;
        e.reg_write  = r | ld | im | jr | jl | lui | aui | mul | dv;
        e.alu_op     = (r | im) ? riscv_pkg::ALU_FUNCT : br ? riscv_pkg::ALU_SUB :
                       lui ? riscv_pkg::ALU_LUI : mul ? riscv_pkg::ALU_MUL :
                       dv ? riscv_pkg::ALU_DIV : riscv_pkg::ALU_ADD;
        e.jalr       = jr;
        e.op1_pc     = aui;
        e.rs1_used   = r | ld | im | st | br | jr | mul | dv;
        e.rs2_used   = r | st | br | mul | dv;
        e.mul_en     = mul;
        e.div_en     = dv;
        // Field placed at the top, then arithmetic shift down for the sign
        case (e.imm_src)
            riscv_pkg::IMM_S: t = $signed({instr[31:25], instr[11:7], 20'b0}) >>> 20;
            riscv_pkg::IMM_B: begin
                t = $signed({instr[31], instr[7], instr[30:25], instr[11:8], 20'b0}) >>> 19;
            end
            riscv_pkg::IMM_J: begin
                t = $signed({instr[31], instr[19:12], instr[20], instr[30:21], 12'b0}) >>> 11;
            end
            riscv_pkg::IMM_U: t = {instr[31:12], 12'b0};
            default:          t = $signed(instr) >>> 20;
        endcase
        e.imm = t;
        return e;
    endfunction

    task automatic build_stimulus;
        riscv_pkg::opcode_t op;
        logic [31:0]        r;
        for (int i = 0; i < NUM_INSTR; i++) begin
            r = $random(seed);
            if (i < 11)
                op = legal_ops[i]; // Every legal opcode at least once
            else if (i == 11)
                op = '0;
            else if (r[2:0] < 3'd2) begin
                op = 7'($random(seed));
                while (is_legal(op))
                    op = op + 7'd1;
            end else
                op = legal_ops[{$random(seed)} % 11];
            stim.push_back({r[31:7], op});
            src_gap.push_back(({$random(seed)} % 4 == 0) ? {$random(seed)} % 6 : 0);
            ret_gap.push_back((i % 12 == 5) ? 40 + {$random(seed)} % 40 : {$random(seed)} % 3);
        end
    endtask

    task automatic source_cycle;
        @(negedge clk);
        in_valid = 1'b0;
        if (in_credit)
            credit_pulses++;
        if (1 + credit_pulses - sent > 1)
            stop_with_failure("source was given more than its one credit");
    endtask

    task automatic run_source;
        int waited;
        repeat (8) begin
            source_cycle();
            check_value("in_credit", 32'd0, in_credit); // Quiet before the first send
            check_value("out_valid", 32'd0, out_valid);
        end
        foreach (stim[i]) begin
            repeat (src_gap[i]) source_cycle();
            waited = 0;
            while (1 + credit_pulses - sent == 0) begin
                source_cycle();
                waited++;
                if (waited > TIMEOUT)
                    stop_with_failure("timed out waiting for an in_credit pulse");
            end
            in_valid = 1'b1;
            in_instr = stim[i];
            exp_q.push_back(expected_decode(stim[i], RESET_PC + pipe_pkg::pc_t'(4 * i)));
            sent++;
        end
        source_cycle();
    endtask

    task automatic run_consumer;
        int gap_left;
        gap_left = ret_gap[0];
        forever begin
            @(negedge clk);
            out_credit = 1'b0;
            if (out_valid) begin
                pulses++;
                owed++;
                if (pulses > returned + OUT_CREDITS)
                    stop_with_failure("out_valid pulses exceed the credits returned");
            end
            if (gap_left > 0)
                gap_left--;
            else if (owed > 0) begin
                out_credit = 1'b1;
                owed--;
                returned++;
                gap_left = ret_gap[returned % ret_gap.size()];
            end
        end
    endtask

    task automatic run_checker;
        expect_t e;
        forever begin
            @(negedge clk);
            if (out_valid && exp_q.size() == 0)
                stop_with_failure("out_valid seen with no instruction outstanding");
            else if (out_valid) begin
                e = exp_q.pop_front();
                check_value("out_pc", e.pc, out_pc);
                check_value("out_imm", e.imm, out_imm);
                check_value("out_illegal", e.illegal, out_illegal);
                check_value("out_jump", e.jump, out_jump);
                check_value("out_branch", e.branch, out_branch);
                check_value("out_result_src", e.result_src, out_result_src);
                check_value("out_mem_write", e.mem_write, out_mem_write);
                check_value("out_alu_src", e.alu_src, out_alu_src);
                check_value("out_imm_src", e.imm_src, out_imm_src);
                check_value("out_reg_write", e.reg_write, out_reg_write);
                check_value("out_alu_op", e.alu_op, out_alu_op);
                check_value("out_jalr", e.jalr, out_jalr);
                check_value("out_op1_pc", e.op1_pc, out_op1_pc);
                check_value("out_rs1_used", e.rs1_used, out_rs1_used);
                check_value("out_rs2_used", e.rs2_used, out_rs2_used);
                check_value("out_mul_en", e.mul_en, out_mul_en);
                check_value("out_div_en", e.div_en, out_div_en);
                received++;
            end
        end
    endtask

    initial begin
        int waited;
        in_valid   = 1'b0;
        in_instr   = '0;
        out_credit = 1'b0;
        legal_ops  = '{riscv_pkg::OP_R, riscv_pkg::OP_LOAD, riscv_pkg::OP_IMM,
                       riscv_pkg::OP_STORE, riscv_pkg::OP_BRANCH, riscv_pkg::OP_JALR,
                       riscv_pkg::OP_JAL, riscv_pkg::OP_LUI, riscv_pkg::OP_AUIPC,
                       riscv_pkg::OP_MUL, riscv_pkg::OP_DIV};
        build_stimulus();
        waited = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                stop_with_failure("timed out waiting for reset to be released");
        end
        fork
            run_consumer();
            run_checker();
        join_none
        run_source();
        waited = 0;
        while (received < sent) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                stop_with_failure("timed out waiting for the last decoded outputs");
        end
        repeat (20) @(negedge clk); // Room for a stray extra out_valid
        if (sent == NUM_INSTR && received == sent && exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("sent %0d instructions but received %0d", sent, received);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule
